/* testbench/id_trace.txt */
# name in_flags pc instr reg1_rdata reg2_rdata ex_wd ex_wdata ex_aluop mem_wd mem_wdata, then expected
# out_flags reg1_addr reg2_addr aluop alusel reg1 reg2 wd branch_target link_addr, all hex
# in_flags {ex_wreg mem_wreg in_delayslot}; out_flags {reg1_read reg2_read wreg branch_flag next_ds ds_out stall}
reset_alu 7 100 00221820 aa bb 1 cc e3 2 dd 0 0 0 0 0 0 0 0 0 0
reset_jal 1 100 0c000040 aa bb 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
reset_beq 0 100 10220004 9 9 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
add_r 0 100 00221820 5 7 0 0 0 0 0 70 1 2 20 4 5 7 3 0 0
nor_r 0 100 00221827 5 7 0 0 0 0 0 70 1 2 27 1 5 7 3 0 0
ori_imm 0 100 34228001 5 7 0 0 0 0 0 50 1 2 25 1 5 8001 2 0 0
lui_imm 0 100 3c021234 5 7 0 0 0 0 0 50 0 2 25 1 5 12340000 2 0 0
addi_neg 0 100 2022fffc 5 7 0 0 0 0 0 50 1 2 55 4 5 fffffffc 2 0 0
sll_shamt 0 100 00021940 5 7 0 0 0 0 0 30 0 2 7c 2 5 7 3 0 0
unknown_op 0 100 70221802 5 7 0 0 0 0 0 0 1 2 0 0 0 0 3 0 0
fwd_ex_over_mem 6 100 00221820 5 7 1 111 0 1 222 70 1 2 20 4 111 7 3 0 0
fwd_mem_only 6 100 00221820 5 7 4 111 0 2 222 70 1 2 20 4 5 222 3 0 0
fwd_no_match 6 100 00221820 5 7 4 111 0 5 222 70 1 2 20 4 5 7 3 0 0
stall_load_use 4 100 00221820 5 7 2 111 e3 0 0 71 1 2 20 4 5 111 3 0 0
nostall_load_other 4 100 00221820 5 7 4 111 e3 0 0 70 1 2 20 4 5 7 3 0 0
nostall_alu_op 4 100 00221820 5 7 2 111 20 0 0 70 1 2 20 4 5 111 3 0 0
nostall_unread_rt 4 100 34228001 5 7 2 111 e0 0 0 50 1 2 25 1 5 8001 2 0 0
beq_taken 0 100 10220004 9 9 0 0 0 0 0 6c 1 2 51 6 9 9 0 114 0
beq_not 0 100 10220004 9 8 0 0 0 0 0 60 1 2 51 6 9 8 0 0 0
bne_taken 0 100 1422fffe 9 8 0 0 0 0 0 6c 1 2 52 6 9 8 1f fc 0
bne_not 0 100 1422fffe 9 9 0 0 0 0 0 60 1 2 52 6 9 9 1f 0 0
bgtz_taken 0 100 1c200004 1 7 0 0 0 0 0 4c 1 0 54 6 1 0 0 114 0
bgtz_not 0 100 1c200004 80000000 7 0 0 0 0 0 40 1 0 54 6 80000000 0 0 0 0
blez_taken 0 100 18200004 0 7 0 0 0 0 0 4c 1 0 53 6 0 0 0 114 0
blez_not 0 100 18200004 1 7 0 0 0 0 0 40 1 0 53 6 1 0 0 0 0
bgez_taken 0 100 04210004 0 7 0 0 0 0 0 4c 1 1 41 6 0 0 0 114 0
bgez_not 0 100 04210004 ffffffff 7 0 0 0 0 0 40 1 1 41 6 ffffffff 0 0 0 0
bltz_taken 0 100 04200004 ffffffff 7 0 0 0 0 0 4c 1 0 40 6 ffffffff 0 0 114 0
bltz_not 0 100 04200004 0 7 0 0 0 0 0 40 1 0 40 6 0 0 0 0 0
bgezal_taken 0 100 04310004 5 7 0 0 0 0 0 5c 1 11 4b 6 5 0 1f 114 108
bgezal_not 0 100 04310004 80000000 7 0 0 0 0 0 50 1 11 4b 6 80000000 0 1f 0 108
bltzal_taken 0 100 04300004 80000000 7 0 0 0 0 0 5c 1 10 4a 6 80000000 0 1f 114 108
bltzal_not 0 100 04300004 5 7 0 0 0 0 0 50 1 10 4a 6 5 0 1f 0 108
j_region 0 30000100 08000040 5 7 0 0 0 0 0 0c 0 0 4f 6 0 0 0 30000100 0
jal_link 0 100 0c000040 5 7 0 0 0 0 0 1c 0 0 50 6 0 0 1f 100 108
jr_reg 0 100 00200008 2000 7 0 0 0 0 0 4c 1 0 08 6 2000 0 0 2000 0
jalr_link 0 100 0020f809 2000 7 0 0 0 0 0 5c 1 0 09 6 2000 0 1f 2000 108
delay_slot_add 1 104 00221820 5 7 0 0 0 0 0 72 1 2 20 4 5 7 3 0 0

/* compile.f */
verilog/id_pkg.sv
verilog/decode_if.sv
verilog/instr_decoder.sv
verilog/operand_forward.sv
verilog/branch_resolve.sv
verilog/id_stage.sv
testbench/id_checker.sv
testbench/id_stage_tb.sv

/* Makefile */
TOP = id_stage_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f compile.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

/* testbench/id_stage_tb.sv */
module id_stage_tb;
	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 3;
	localparam int TRACE_FIELDS = 21;

	logic clk = 1'b0;
	logic rst;
	id_pkg::word_t pc;
	id_pkg::word_t instr;
	id_pkg::word_t reg1_rdata;
	id_pkg::word_t reg2_rdata;
	logic ex_wreg;
	id_pkg::reg_addr_t ex_wd;
	id_pkg::word_t ex_wdata;
	id_pkg::aluop_t ex_aluop;
	logic mem_wreg;
	id_pkg::reg_addr_t mem_wd;
	id_pkg::word_t mem_wdata;
	logic in_delayslot;

	logic reg1_read;
	logic reg2_read;
	id_pkg::reg_addr_t reg1_addr;
	id_pkg::reg_addr_t reg2_addr;
	id_pkg::aluop_t aluop;
	id_pkg::alusel_t alusel;
	id_pkg::word_t reg1;
	id_pkg::word_t reg2;
	id_pkg::reg_addr_t wd;
	logic wreg;
	logic branch_flag;
	id_pkg::word_t branch_target;
	id_pkg::word_t link_addr;
	logic next_in_delayslot;
	logic in_delayslot_out;
	logic stall;

	// Expected response of the current trace line.
	logic [6:0] exp_flags;
	id_pkg::reg_addr_t exp_reg1_addr;
	id_pkg::reg_addr_t exp_reg2_addr;
	id_pkg::aluop_t exp_aluop;
	id_pkg::alusel_t exp_alusel;
	id_pkg::word_t exp_reg1;
	id_pkg::word_t exp_reg2;
	id_pkg::reg_addr_t exp_wd;
	id_pkg::word_t exp_branch_target;
	id_pkg::word_t exp_link_addr;

	logic [2:0] in_flags; // {ex_wreg, mem_wreg, in_delayslot} from the trace.
	string test_name;
	string trace_lines[$];
	logic check_en;
	logic loaded;
	int bad_lines;
	int checks;
	int errors;

	id_stage dut_i (.*);

	id_checker monitor_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Each cycle takes one trace line and drives it just after the rising edge.
	task automatic apply_trace();
		int n;
		for (int i = 0; i < trace_lines.size(); i++)
		begin
			@(posedge clk);
			#10;
			rst = (i < RESET_CYCLES);
			n = $sscanf(trace_lines[i],
				"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				test_name, in_flags, pc, instr, reg1_rdata, reg2_rdata, ex_wd, ex_wdata, ex_aluop,
				mem_wd, mem_wdata, exp_flags, exp_reg1_addr, exp_reg2_addr, exp_aluop, exp_alusel,
				exp_reg1, exp_reg2, exp_wd, exp_branch_target, exp_link_addr);
			ex_wreg = in_flags[2];
			mem_wreg = in_flags[1];
			in_delayslot = in_flags[0];
			check_en = (n == TRACE_FIELDS);
			if (n != TRACE_FIELDS)
			begin
				bad_lines++;
				$display("Trace line %0d has %0d fields where %0d are needed", i + 1, n,
					TRACE_FIELDS);
			end
		end
		@(posedge clk);
		#10;
		check_en = 1'b0;
	endtask

	initial
	begin
		int fd;
		string line;
		rst = 1'b1;
		pc = '0;
		instr = '0;
		reg1_rdata = '0;
		reg2_rdata = '0;
		ex_wreg = 1'b0;
		ex_wd = '0;
		ex_wdata = '0;
		ex_aluop = '0;
		mem_wreg = 1'b0;
		mem_wd = '0;
		mem_wdata = '0;
		in_delayslot = 1'b0;
		check_en = 1'b0;
		loaded = 1'b0;
		bad_lines = 0;
		fd = $fopen("testbench/id_trace.txt", "r");
		if (fd == 0)
			$display("Could not open testbench/id_trace.txt for reading");
		else
		begin
			while ($fgets(line, fd) != 0)
				if (line.len() > 1 && line.getc(0) != "#")
					trace_lines.push_back(line);
			$fclose(fd);
			loaded = 1'b1;
			apply_trace();
		end
		$display("Tests %0d, checks %0d, mismatches %0d, bad trace lines %0d",
			trace_lines.size(), checks, errors, bad_lines);
		if (fd != 0 && checks > 0 && errors == 0 && bad_lines == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		wait (loaded);
		#((trace_lines.size() + 10) * CLK_PERIOD);
		$display("Timeout: the trace did not finish within %0d cycles", trace_lines.size() + 10);
		$display("=== FAIL ===");
		$finish;
	end
endmodule

/* testbench/id_checker.sv */
module id_checker (
	input logic clk,
	input logic check_en,
	input string test_name,
	input logic reg1_read,
	input logic reg2_read,
	input id_pkg::reg_addr_t reg1_addr,
	input id_pkg::reg_addr_t reg2_addr,
	input id_pkg::aluop_t aluop,
	input id_pkg::alusel_t alusel,
	input id_pkg::word_t reg1,
	input id_pkg::word_t reg2,
	input id_pkg::reg_addr_t wd,
	input logic wreg,
	input logic branch_flag,
	input id_pkg::word_t branch_target,
	input id_pkg::word_t link_addr,
	input logic next_in_delayslot,
	input logic in_delayslot_out,
	input logic stall,
	input logic [6:0] exp_flags,
	input id_pkg::reg_addr_t exp_reg1_addr,
	input id_pkg::reg_addr_t exp_reg2_addr,
	input id_pkg::aluop_t exp_aluop,
	input id_pkg::alusel_t exp_alusel,
	input id_pkg::word_t exp_reg1,
	input id_pkg::word_t exp_reg2,
	input id_pkg::reg_addr_t exp_wd,
	input id_pkg::word_t exp_branch_target,
	input id_pkg::word_t exp_link_addr,
	output int checks,
	output int errors
);
	int check_count = 0;
	int error_count = 0;

	assign checks = check_count;
	assign errors = error_count;

	task automatic compare(
		input string field,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Fail %0s %0s expected %0h actual %0h", test_name, field, expected, actual);
		end
	endtask

	// The stage is combinational, so the falling edge sees a settled response.
	always @(negedge clk)
		if (check_en)
		begin
			compare("reg1_read", 32'(exp_flags[6]), 32'(reg1_read));
			compare("reg2_read", 32'(exp_flags[5]), 32'(reg2_read));
			compare("wreg", 32'(exp_flags[4]), 32'(wreg));
			compare("branch_flag", 32'(exp_flags[3]), 32'(branch_flag));
			compare("next_in_delayslot", 32'(exp_flags[2]), 32'(next_in_delayslot));
			compare("in_delayslot_out", 32'(exp_flags[1]), 32'(in_delayslot_out));
			compare("stall", 32'(exp_flags[0]), 32'(stall));
			compare("reg1_addr", 32'(exp_reg1_addr), 32'(reg1_addr));
			compare("reg2_addr", 32'(exp_reg2_addr), 32'(reg2_addr));
			compare("aluop", 32'(exp_aluop), 32'(aluop));
			compare("alusel", 32'(exp_alusel), 32'(alusel));
			compare("reg1", exp_reg1, reg1);
			compare("reg2", exp_reg2, reg2);
			compare("wd", 32'(exp_wd), 32'(wd));
			compare("branch_target", exp_branch_target, branch_target);
			compare("link_addr", exp_link_addr, link_addr);
		end
endmodule

/* verilog/id_stage.sv */
module id_stage (
	input logic rst,
	input id_pkg::word_t pc,
	input id_pkg::word_t instr,
	input id_pkg::word_t reg1_rdata,
	input id_pkg::word_t reg2_rdata,
	input logic ex_wreg,
	input id_pkg::reg_addr_t ex_wd,
	input id_pkg::word_t ex_wdata,
	input id_pkg::aluop_t ex_aluop,
	input logic mem_wreg,
	input id_pkg::reg_addr_t mem_wd,
	input id_pkg::word_t mem_wdata,
	input logic in_delayslot,
	output logic reg1_read,
	output logic reg2_read,
	output id_pkg::reg_addr_t reg1_addr,
	output id_pkg::reg_addr_t reg2_addr,
	output id_pkg::aluop_t aluop,
	output id_pkg::alusel_t alusel,
	output id_pkg::word_t reg1,
	output id_pkg::word_t reg2,
	output id_pkg::reg_addr_t wd,
	output logic wreg,
	output logic branch_flag,
	output id_pkg::word_t branch_target,
	output id_pkg::word_t link_addr,
	output logic next_in_delayslot,
	output logic in_delayslot_out,
	output logic stall
);
	decode_if dec_bus ();

	instr_decoder decoder_i (
		.rst(rst),
		.instr(instr),
		.dec(dec_bus)
	);

	operand_forward forward_i (
		.rst(rst),
		.dec(dec_bus),
		.reg1_rdata(reg1_rdata),
		.reg2_rdata(reg2_rdata),
		.ex_wreg(ex_wreg),
		.ex_wd(ex_wd),
		.ex_wdata(ex_wdata),
		.ex_aluop(ex_aluop),
		.mem_wreg(mem_wreg),
		.mem_wd(mem_wd),
		.mem_wdata(mem_wdata),
		.reg1(reg1),
		.reg2(reg2),
		.stall(stall)
	);

	branch_resolve branch_i (
		.rst(rst),
		.dec(dec_bus),
		.pc(pc),
		.instr(instr),
		.reg1(reg1),
		.reg2(reg2),
		.in_delayslot(in_delayslot),
		.branch_flag(branch_flag),
		.branch_target(branch_target),
		.link_addr(link_addr),
		.next_in_delayslot(next_in_delayslot),
		.in_delayslot_out(in_delayslot_out)
	);

	// Register file read port and EX control come straight off the decode bus.
	assign reg1_read = dec_bus.reg1_read;
	assign reg2_read = dec_bus.reg2_read;
	assign reg1_addr = dec_bus.reg1_addr;
	assign reg2_addr = dec_bus.reg2_addr;
	assign aluop = dec_bus.aluop;
	assign alusel = dec_bus.alusel;
	assign wd = dec_bus.wd;
	assign wreg = dec_bus.wreg;
endmodule

/* verilog/branch_resolve.sv */
module branch_resolve (
	input logic rst,
	decode_if.branch dec,
	input id_pkg::word_t pc,
	input id_pkg::word_t instr,
	input id_pkg::word_t reg1,
	input id_pkg::word_t reg2,
	input logic in_delayslot,
	output logic branch_flag,
	output id_pkg::word_t branch_target,
	output id_pkg::word_t link_addr,
	output logic next_in_delayslot,
	output logic in_delayslot_out
);
	id_pkg::word_t pc_plus4;
	id_pkg::word_t pc_plus8;
	id_pkg::word_t br_offset;
	logic taken;

	assign pc_plus4 = pc + 32'd4;
	assign pc_plus8 = pc + 32'd8; // Return lands past the delay slot.
	assign br_offset = {{14{instr[15]}}, instr[15:0], 2'b00};

	always_comb
	begin
		taken = 1'b0;
		if (!rst)
			case (dec.br_cond)
			id_pkg::BR_JUMP, id_pkg::BR_JUMP_REG: taken = 1'b1;
			id_pkg::BR_EQ: taken = (reg1 == reg2);
			id_pkg::BR_NE: taken = (reg1 != reg2);
			id_pkg::BR_GTZ: taken = !reg1[31] && (reg1 != '0);
			id_pkg::BR_LEZ: taken = reg1[31] || (reg1 == '0);
			id_pkg::BR_GEZ: taken = !reg1[31];
			id_pkg::BR_LTZ: taken = reg1[31];
			default: taken = 1'b0;
			endcase
	end

	always_comb
	begin
		branch_target = '0;
		if (taken)
			case (dec.br_cond)
			id_pkg::BR_JUMP: branch_target = {pc_plus4[31:28], instr[25:0], 2'b00};
			id_pkg::BR_JUMP_REG: branch_target = reg1;
			default: branch_target = pc_plus4 + br_offset;
			endcase
	end

	assign branch_flag = taken;
	assign next_in_delayslot = taken; // The next fetch is the delay slot of this branch.
	assign link_addr = (!rst && dec.link) ? pc_plus8 : '0;
	assign in_delayslot_out = !rst && in_delayslot;
endmodule

/* verilog/operand_forward.sv */
module operand_forward (
	input logic rst,
	decode_if.operands dec,
	input id_pkg::word_t reg1_rdata,
	input id_pkg::word_t reg2_rdata,
	input logic ex_wreg,
	input id_pkg::reg_addr_t ex_wd,
	input id_pkg::word_t ex_wdata,
	input id_pkg::aluop_t ex_aluop,
	input logic mem_wreg,
	input id_pkg::reg_addr_t mem_wd,
	input id_pkg::word_t mem_wdata,
	output id_pkg::word_t reg1,
	output id_pkg::word_t reg2,
	output logic stall
);
	logic ex_load;

	// The newest producer wins. EX is one instruction younger than MEM.
	function automatic id_pkg::word_t pick(
		input logic rd_en,
		input id_pkg::reg_addr_t addr,
		input id_pkg::word_t rf_data
	);
		if (!rd_en)
			pick = dec.imm;
		else if (ex_wreg && (ex_wd == addr))
			pick = ex_wdata;
		else if (mem_wreg && (mem_wd == addr))
			pick = mem_wdata;
		else
			pick = rf_data;
	endfunction

	assign ex_load = ex_aluop inside {id_pkg::ALUOP_LB, id_pkg::ALUOP_LBU, id_pkg::ALUOP_LH,
		id_pkg::ALUOP_LHU, id_pkg::ALUOP_LW};

	always_comb
	begin
		if (rst)
		begin
			reg1 = '0;
			reg2 = '0;
			stall = 1'b0;
		end
		else
		begin
			reg1 = pick(dec.reg1_read, dec.reg1_addr, reg1_rdata);
			reg2 = pick(dec.reg2_read, dec.reg2_addr, reg2_rdata);
			// Load data only exists after MEM, so a consumer right behind the load must wait.
			stall = ex_load && ((dec.reg1_read && (dec.reg1_addr == ex_wd)) ||
				(dec.reg2_read && (dec.reg2_addr == ex_wd)));
		end
	end
endmodule

/* verilog/instr_decoder.sv */
module instr_decoder (
	input logic rst,
	input id_pkg::word_t instr,
	decode_if.decoder dec
);
	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] rt;
	logic fixed_shift;
	logic jump_reg;
	id_pkg::aluop_t tab_op;
	id_pkg::alusel_t tab_sel;

	assign op = instr[31:26];
	assign funct = instr[5:0];
	assign rt = instr[20:16];
	assign fixed_shift = (funct == id_pkg::FN_SLL) || (funct == id_pkg::FN_SRL) ||
		(funct == id_pkg::FN_SRA);
	assign jump_reg = (funct == id_pkg::FN_JR) || (funct == id_pkg::FN_JALR);

	// ALU op and result group of each supported encoding. Anything else stays NOP.
	always_comb
	begin
		tab_op = id_pkg::ALUOP_NOP;
		tab_sel = id_pkg::SEL_NOP;
		case (op)
		id_pkg::OP_SPECIAL:
			case (funct)
			id_pkg::FN_OR: {tab_op, tab_sel} = {id_pkg::ALUOP_OR, id_pkg::SEL_LOGIC};
			id_pkg::FN_AND: {tab_op, tab_sel} = {id_pkg::ALUOP_AND, id_pkg::SEL_LOGIC};
			id_pkg::FN_XOR: {tab_op, tab_sel} = {id_pkg::ALUOP_XOR, id_pkg::SEL_LOGIC};
			id_pkg::FN_NOR: {tab_op, tab_sel} = {id_pkg::ALUOP_NOR, id_pkg::SEL_LOGIC};
			id_pkg::FN_SLL: {tab_op, tab_sel} = {id_pkg::ALUOP_SLL, id_pkg::SEL_SHIFT};
			id_pkg::FN_SRL: {tab_op, tab_sel} = {id_pkg::ALUOP_SRL, id_pkg::SEL_SHIFT};
			id_pkg::FN_SRA: {tab_op, tab_sel} = {id_pkg::ALUOP_SRA, id_pkg::SEL_SHIFT};
			id_pkg::FN_SLLV: {tab_op, tab_sel} = {id_pkg::ALUOP_SLL, id_pkg::SEL_SHIFT};
			id_pkg::FN_SRLV: {tab_op, tab_sel} = {id_pkg::ALUOP_SRL, id_pkg::SEL_SHIFT};
			id_pkg::FN_SRAV: {tab_op, tab_sel} = {id_pkg::ALUOP_SRA, id_pkg::SEL_SHIFT};
			id_pkg::FN_SLT: {tab_op, tab_sel} = {id_pkg::ALUOP_SLT, id_pkg::SEL_ARITH};
			id_pkg::FN_SLTU: {tab_op, tab_sel} = {id_pkg::ALUOP_SLTU, id_pkg::SEL_ARITH};
			id_pkg::FN_ADD: {tab_op, tab_sel} = {id_pkg::ALUOP_ADD, id_pkg::SEL_ARITH};
			id_pkg::FN_ADDU: {tab_op, tab_sel} = {id_pkg::ALUOP_ADDU, id_pkg::SEL_ARITH};
			id_pkg::FN_SUB: {tab_op, tab_sel} = {id_pkg::ALUOP_SUB, id_pkg::SEL_ARITH};
			id_pkg::FN_SUBU: {tab_op, tab_sel} = {id_pkg::ALUOP_SUBU, id_pkg::SEL_ARITH};
			id_pkg::FN_JR: {tab_op, tab_sel} = {id_pkg::ALUOP_JR, id_pkg::SEL_JUMP_BRANCH};
			id_pkg::FN_JALR: {tab_op, tab_sel} = {id_pkg::ALUOP_JALR, id_pkg::SEL_JUMP_BRANCH};
			default: ;
			endcase
		id_pkg::OP_REGIMM:
		begin
			case (rt)
			id_pkg::RT_BGEZ: tab_op = id_pkg::ALUOP_BGEZ;
			id_pkg::RT_BLTZ: tab_op = id_pkg::ALUOP_BLTZ;
			id_pkg::RT_BGEZAL: tab_op = id_pkg::ALUOP_BGEZAL;
			id_pkg::RT_BLTZAL: tab_op = id_pkg::ALUOP_BLTZAL;
			default: ;
			endcase
			if (tab_op != id_pkg::ALUOP_NOP)
				tab_sel = id_pkg::SEL_JUMP_BRANCH;
		end
		id_pkg::OP_ORI: {tab_op, tab_sel} = {id_pkg::ALUOP_OR, id_pkg::SEL_LOGIC};
		id_pkg::OP_ANDI: {tab_op, tab_sel} = {id_pkg::ALUOP_AND, id_pkg::SEL_LOGIC};
		id_pkg::OP_XORI: {tab_op, tab_sel} = {id_pkg::ALUOP_XOR, id_pkg::SEL_LOGIC};
		id_pkg::OP_LUI: {tab_op, tab_sel} = {id_pkg::ALUOP_OR, id_pkg::SEL_LOGIC};
		id_pkg::OP_ADDI: {tab_op, tab_sel} = {id_pkg::ALUOP_ADDI, id_pkg::SEL_ARITH};
		id_pkg::OP_ADDIU: {tab_op, tab_sel} = {id_pkg::ALUOP_ADDIU, id_pkg::SEL_ARITH};
		id_pkg::OP_SLTI: {tab_op, tab_sel} = {id_pkg::ALUOP_SLT, id_pkg::SEL_ARITH};
		id_pkg::OP_SLTIU: {tab_op, tab_sel} = {id_pkg::ALUOP_SLTU, id_pkg::SEL_ARITH};
		id_pkg::OP_J: {tab_op, tab_sel} = {id_pkg::ALUOP_J, id_pkg::SEL_JUMP_BRANCH};
		id_pkg::OP_JAL: {tab_op, tab_sel} = {id_pkg::ALUOP_JAL, id_pkg::SEL_JUMP_BRANCH};
		id_pkg::OP_BEQ: {tab_op, tab_sel} = {id_pkg::ALUOP_BEQ, id_pkg::SEL_JUMP_BRANCH};
		id_pkg::OP_BNE: {tab_op, tab_sel} = {id_pkg::ALUOP_BNE, id_pkg::SEL_JUMP_BRANCH};
		id_pkg::OP_BGTZ: {tab_op, tab_sel} = {id_pkg::ALUOP_BGTZ, id_pkg::SEL_JUMP_BRANCH};
		id_pkg::OP_BLEZ: {tab_op, tab_sel} = {id_pkg::ALUOP_BLEZ, id_pkg::SEL_JUMP_BRANCH};
		id_pkg::OP_LB: {tab_op, tab_sel} = {id_pkg::ALUOP_LB, id_pkg::SEL_LOAD_STORE};
		id_pkg::OP_LBU: {tab_op, tab_sel} = {id_pkg::ALUOP_LBU, id_pkg::SEL_LOAD_STORE};
		id_pkg::OP_LH: {tab_op, tab_sel} = {id_pkg::ALUOP_LH, id_pkg::SEL_LOAD_STORE};
		id_pkg::OP_LHU: {tab_op, tab_sel} = {id_pkg::ALUOP_LHU, id_pkg::SEL_LOAD_STORE};
		id_pkg::OP_LW: {tab_op, tab_sel} = {id_pkg::ALUOP_LW, id_pkg::SEL_LOAD_STORE};
		id_pkg::OP_SB: {tab_op, tab_sel} = {id_pkg::ALUOP_SB, id_pkg::SEL_LOAD_STORE};
		id_pkg::OP_SH: {tab_op, tab_sel} = {id_pkg::ALUOP_SH, id_pkg::SEL_LOAD_STORE};
		id_pkg::OP_SW: {tab_op, tab_sel} = {id_pkg::ALUOP_SW, id_pkg::SEL_LOAD_STORE};
		default: ;
		endcase
	end

	always_comb
	begin
		dec.aluop = tab_op;
		dec.alusel = tab_sel;
		dec.reg1_read = 1'b0;
		dec.reg2_read = 1'b0;
		dec.reg1_addr = instr[25:21];
		dec.reg2_addr = rt;
		dec.imm = '0;
		dec.wd = instr[15:11];
		dec.wreg = 1'b0;
		dec.br_cond = id_pkg::BR_NONE;
		dec.link = 1'b0;
		if (rst)
		begin
			dec.aluop = id_pkg::ALUOP_NOP;
			dec.alusel = id_pkg::SEL_NOP;
			dec.reg1_addr = '0;
			dec.reg2_addr = '0;
			dec.wd = '0;
		end
		else if (tab_sel != id_pkg::SEL_NOP)
		begin
			case (op)
			id_pkg::OP_SPECIAL:
			begin
				dec.reg1_read = !fixed_shift; // Fixed shifts take shamt in place of rs.
				dec.reg2_read = !jump_reg;
				dec.wreg = (funct != id_pkg::FN_JR);
				dec.link = (funct == id_pkg::FN_JALR);
				if (fixed_shift)
					dec.imm = {27'd0, instr[10:6]};
				if (jump_reg)
					dec.br_cond = id_pkg::BR_JUMP_REG;
			end
			id_pkg::OP_REGIMM:
			begin
				dec.reg1_read = 1'b1;
				dec.br_cond = rt[0] ? id_pkg::BR_GEZ : id_pkg::BR_LTZ;
				if (rt[4])
				begin
					dec.wreg = 1'b1;
					dec.wd = id_pkg::LINK_REG;
					dec.link = 1'b1;
				end
			end
			id_pkg::OP_J: dec.br_cond = id_pkg::BR_JUMP;
			id_pkg::OP_JAL:
			begin
				dec.br_cond = id_pkg::BR_JUMP;
				dec.wreg = 1'b1;
				dec.wd = id_pkg::LINK_REG;
				dec.link = 1'b1;
			end
			id_pkg::OP_BEQ, id_pkg::OP_BNE:
			begin
				dec.reg1_read = 1'b1;
				dec.reg2_read = 1'b1;
				dec.br_cond = (op == id_pkg::OP_BEQ) ? id_pkg::BR_EQ : id_pkg::BR_NE;
			end
			id_pkg::OP_BGTZ, id_pkg::OP_BLEZ:
			begin
				dec.reg1_read = 1'b1;
				dec.br_cond = (op == id_pkg::OP_BGTZ) ? id_pkg::BR_GTZ : id_pkg::BR_LEZ;
			end
			id_pkg::OP_SB, id_pkg::OP_SH, id_pkg::OP_SW:
			begin
				dec.reg1_read = 1'b1;
				dec.reg2_read = 1'b1;
			end
			default:
			begin
				// Immediate ALU ops and loads read rs and write rt.
				dec.reg1_read = 1'b1;
				dec.wreg = 1'b1;
				dec.wd = rt;
				if (tab_sel == id_pkg::SEL_LOGIC)
					dec.imm = (op == id_pkg::OP_LUI) ? {instr[15:0], 16'h0} : {16'h0, instr[15:0]};
				else if (tab_sel == id_pkg::SEL_ARITH)
					dec.imm = {{16{instr[15]}}, instr[15:0]};
			end
			endcase
		end
	end
endmodule

/* verilog/decode_if.sv */
interface decode_if;
	id_pkg::aluop_t aluop;
	id_pkg::alusel_t alusel;
	logic reg1_read;
	logic reg2_read;
	id_pkg::reg_addr_t reg1_addr;
	id_pkg::reg_addr_t reg2_addr;
	id_pkg::word_t imm; // Used in place of a register operand that is not read.
	id_pkg::reg_addr_t wd;
	logic wreg;
	id_pkg::br_cond_t br_cond;
	logic link;

	modport decoder (
		output aluop, alusel, reg1_read, reg2_read, reg1_addr, reg2_addr,
		output imm, wd, wreg, br_cond, link
	);

	modport operands (
		input reg1_read, reg2_read, reg1_addr, reg2_addr, imm
	);

	modport branch (
		input br_cond, link
	);
endinterface

/* verilog/id_pkg.sv */
package id_pkg;
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [7:0] aluop_t;
	typedef logic [2:0] alusel_t;
	typedef logic [3:0] br_cond_t;

	// Primary opcodes sit in instr[31:26].
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM = 6'b000001;
	localparam logic [5:0] OP_J = 6'b000010;
	localparam logic [5:0] OP_JAL = 6'b000011;
	localparam logic [5:0] OP_BEQ = 6'b000100;
	localparam logic [5:0] OP_BNE = 6'b000101;
	localparam logic [5:0] OP_BLEZ = 6'b000110;
	localparam logic [5:0] OP_BGTZ = 6'b000111;
	localparam logic [5:0] OP_ADDI = 6'b001000;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI = 6'b001010;
	localparam logic [5:0] OP_SLTIU = 6'b001011;
	localparam logic [5:0] OP_ANDI = 6'b001100;
	localparam logic [5:0] OP_ORI = 6'b001101;
	localparam logic [5:0] OP_XORI = 6'b001110;
	localparam logic [5:0] OP_LUI = 6'b001111;
	localparam logic [5:0] OP_LB = 6'b100000;
	localparam logic [5:0] OP_LH = 6'b100001;
	localparam logic [5:0] OP_LW = 6'b100011;
	localparam logic [5:0] OP_LBU = 6'b100100;
	localparam logic [5:0] OP_LHU = 6'b100101;
	localparam logic [5:0] OP_SB = 6'b101000;
	localparam logic [5:0] OP_SH = 6'b101001;
	localparam logic [5:0] OP_SW = 6'b101011;

	// SPECIAL funct codes sit in instr[5:0].
	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_SRL = 6'b000010;
	localparam logic [5:0] FN_SRA = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_NOR = 6'b100111;
	localparam logic [5:0] FN_SLT = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// REGIMM rt codes. Bit 0 picks GEZ over LTZ and bit 4 marks the linking forms.
	localparam logic [4:0] RT_BLTZ = 5'b00000;
	localparam logic [4:0] RT_BGEZ = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

	localparam aluop_t ALUOP_NOP = 8'b00000000;
	localparam aluop_t ALUOP_AND = 8'b00100100;
	localparam aluop_t ALUOP_OR = 8'b00100101;
	localparam aluop_t ALUOP_XOR = 8'b00100110;
	localparam aluop_t ALUOP_NOR = 8'b00100111;
	localparam aluop_t ALUOP_SLL = 8'b01111100;
	localparam aluop_t ALUOP_SRL = 8'b00000010;
	localparam aluop_t ALUOP_SRA = 8'b00000011;
	localparam aluop_t ALUOP_SLT = 8'b00101010;
	localparam aluop_t ALUOP_SLTU = 8'b00101011;
	localparam aluop_t ALUOP_ADD = 8'b00100000;
	localparam aluop_t ALUOP_ADDU = 8'b00100001;
	localparam aluop_t ALUOP_SUB = 8'b00100010;
	localparam aluop_t ALUOP_SUBU = 8'b00100011;
	localparam aluop_t ALUOP_ADDI = 8'b01010101;
	localparam aluop_t ALUOP_ADDIU = 8'b01010110;
	localparam aluop_t ALUOP_J = 8'b01001111;
	localparam aluop_t ALUOP_JAL = 8'b01010000;
	localparam aluop_t ALUOP_JR = 8'b00001000;
	localparam aluop_t ALUOP_JALR = 8'b00001001;
	localparam aluop_t ALUOP_BEQ = 8'b01010001;
	localparam aluop_t ALUOP_BNE = 8'b01010010;
	localparam aluop_t ALUOP_BLEZ = 8'b01010011;
	localparam aluop_t ALUOP_BGTZ = 8'b01010100;
	localparam aluop_t ALUOP_BLTZ = 8'b01000000;
	localparam aluop_t ALUOP_BGEZ = 8'b01000001;
	localparam aluop_t ALUOP_BLTZAL = 8'b01001010;
	localparam aluop_t ALUOP_BGEZAL = 8'b01001011;
	localparam aluop_t ALUOP_LB = 8'b11100000;
	localparam aluop_t ALUOP_LH = 8'b11100001;
	localparam aluop_t ALUOP_LW = 8'b11100011;
	localparam aluop_t ALUOP_LBU = 8'b11100100;
	localparam aluop_t ALUOP_LHU = 8'b11100101;
	localparam aluop_t ALUOP_SB = 8'b11101000;
	localparam aluop_t ALUOP_SH = 8'b11101001;
	localparam aluop_t ALUOP_SW = 8'b11101011;

	localparam alusel_t SEL_NOP = 3'b000;
	localparam alusel_t SEL_LOGIC = 3'b001;
	localparam alusel_t SEL_SHIFT = 3'b010;
	localparam alusel_t SEL_ARITH = 3'b100;
	localparam alusel_t SEL_JUMP_BRANCH = 3'b110;
	localparam alusel_t SEL_LOAD_STORE = 3'b111;

	localparam br_cond_t BR_NONE = 4'd0;
	localparam br_cond_t BR_JUMP = 4'd1; // Index jump within the current 256 MB region.
	localparam br_cond_t BR_JUMP_REG = 4'd2;
	localparam br_cond_t BR_EQ = 4'd3;
	localparam br_cond_t BR_NE = 4'd4;
	localparam br_cond_t BR_GTZ = 4'd5;
	localparam br_cond_t BR_LEZ = 4'd6;
	localparam br_cond_t BR_GEZ = 4'd7;
	localparam br_cond_t BR_LTZ = 4'd8;

	localparam reg_addr_t LINK_REG = 5'd31;
endpackage
